// ==== design/fp_params.svh ====
`ifndef FP_PARAMS_SVH
`define FP_PARAMS_SVH

`define FP_MANT_W 32
`define FP_EXP_W 8

// one-shot lengths in clocks
`define FP_STEP_TICKS 3
`define FP_IRQ_TICKS 4

`define FP_ADDR_A_MANT 8'h00
`define FP_ADDR_A_EXP 8'h04
`define FP_ADDR_B_MANT 8'h08
`define FP_ADDR_B_EXP 8'h0C
`define FP_ADDR_CMD 8'h10
`define FP_ADDR_STATUS 8'h14
`define FP_ADDR_R_MANT 8'h18
`define FP_ADDR_R_EXP 8'h1C

`endif

// ==== design/fp_pkg.sv ====
`default_nettype none

`include "fp_params.svh"

package fp_pkg;

	// command codes, as written to the command register
	typedef enum logic [1:0] {
		op_nrf = 2'd0,
		op_ad = 2'd1,
		op_sd = 2'd2
	} fp_op_e;

	// value is mant * 2^exp, both two's complement
	typedef struct packed {
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_MANT_W-1:0] mant;
	} fp_num_t;

	// datapath enables, valid for one clock
	typedef struct packed {
		logic load_a;
		logic load_b;
		logic swap;
		logic align_shift;
		logic add;
		logic sub;
		logic fix_ovf;
		logic norm_shift;
		logic zero_exp;
		logic store;
	} fp_ctl_t;

	typedef struct packed {
		logic exp_a_less;
		logic exp_diff_done;
		logic mant_ovf;
		logic normal;
		logic mant_zero;
		logic exp_range_err;
	} fp_flags_t;

	typedef struct packed {
		logic busy;
		logic ovf;
		logic unf;
		logic zero;
	} fp_status_t;

endpackage

`default_nettype wire

// ==== design/fp_univib.sv ====
`default_nettype none

module fp_univib #(
	parameter int ticks = 1
) (
	input logic got_fp,
	input logic _0_f,
	input logic trig,
	output logic q
);

	localparam int cnt_w = $clog2(ticks + 1);

	logic trig_d;
	logic [cnt_w-1:0] cnt;

	// rising trig (re)loads the count
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			trig_d <= 1'b0;
			cnt <= '0;
		end else begin
			trig_d <= trig;
			if (trig & ~trig_d)
				cnt <= cnt_w'(ticks);
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
		end
	end

	assign q = (cnt != '0);

endmodule

`default_nettype wire

// ==== design/fp_sequencer.sv ====
`default_nettype none

module fp_sequencer (
	input logic got_fp,
	input logic _0_f,
	input logic start,
	input fp_pkg::fp_op_e op,
	input fp_pkg::fp_flags_t flags,
	input logic step_busy,
	output logic step_trig,
	output fp_pkg::fp_ctl_t ctl,
	output logic irq_trig,
	output fp_pkg::fp_status_t status
);

	import fp_pkg::*;

	// one-hot state flags
	typedef struct packed {
		logic idle;
		logic load;
		logic swap;
		logic align;
		logic add;
		logic fix;
		logic normalize;
		logic store;
		logic done;
	} st_t;

	localparam st_t st_idle = '{idle: 1'b1, default: 1'b0};

	st_t st;
	st_t st_n;
	fp_op_e op_q;
	logic armed;
	logic en;
	logic go;
	logic [4:0] loop_cnt;

	assign go = (st.idle | st.done) & start;

	// enable cycle comes once the step pulse has run out
	assign en = armed & ~step_busy;

	always_comb begin
		st_n = st;
		ctl = '0;
		step_trig = 1'b0;
		irq_trig = 1'b0;
		if (go) begin
			st_n = '0;
			st_n.load = 1'b1;
			step_trig = 1'b1;
		end else if (st.done) begin
			st_n = st_idle;
		end else if (en) begin
			st_n = '0;
			step_trig = 1'b1;
			if (st.load) begin
				ctl.load_a = 1'b1;
				ctl.load_b = 1'b1;
				if (op_q == op_nrf)
					st_n.normalize = 1'b1;
				else
					st_n.swap = 1'b1;
			end
			if (st.swap) begin
				// larger exponent goes to the accumulator
				ctl.swap = flags.exp_a_less;
				st_n.align = 1'b1;
			end
			if (st.align) begin
				if (flags.exp_diff_done | (&loop_cnt)) begin
					st_n.add = 1'b1;
				end else begin
					ctl.align_shift = 1'b1;
					st_n.align = 1'b1;
				end
			end
			if (st.add) begin
				ctl.sub = (op_q == op_sd);
				ctl.add = (op_q != op_sd);
				st_n.fix = 1'b1;
			end
			if (st.fix) begin
				ctl.fix_ovf = flags.mant_ovf;
				st_n.normalize = 1'b1;
			end
			if (st.normalize) begin
				if (flags.mant_zero) begin
					ctl.zero_exp = 1'b1;
					st_n.store = 1'b1;
				end else if (flags.normal) begin
					st_n.store = 1'b1;
				end else begin
					ctl.norm_shift = 1'b1;
					st_n.normalize = 1'b1;
				end
			end
			if (st.store) begin
				ctl.store = 1'b1;
				irq_trig = 1'b1;
				step_trig = 1'b0;
				st_n.done = 1'b1;
			end
		end
	end

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			st <= st_idle;
			op_q <= op_nrf;
			armed <= 1'b0;
			loop_cnt <= '0;
			status <= '0;
		end else begin
			st <= st_n;
			if (step_trig)
				armed <= 1'b1;
			else if (en)
				armed <= 1'b0;
			if (go) begin
				op_q <= op;
				loop_cnt <= '0;
				status <= '{busy: 1'b1, default: 1'b0};
			end
			if (ctl.align_shift)
				loop_cnt <= loop_cnt + 1'b1;
			// exponent wraps, only the flag remembers it
			if (ctl.fix_ovf & flags.exp_range_err)
				status.ovf <= 1'b1;
			if (ctl.norm_shift & flags.exp_range_err)
				status.unf <= 1'b1;
			if (ctl.store) begin
				status.busy <= 1'b0;
				status.zero <= flags.mant_zero;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/fp_datapath.sv ====
`default_nettype none

`include "fp_params.svh"

module fp_datapath (
	input logic got_fp,
	input logic _0_f,
	input fp_pkg::fp_num_t a,
	input fp_pkg::fp_num_t b,
	input fp_pkg::fp_ctl_t ctl,
	output fp_pkg::fp_flags_t flags,
	output fp_pkg::fp_num_t result
);

	import fp_pkg::*;

	localparam int mant_w = `FP_MANT_W;
	localparam int exp_w = `FP_EXP_W;
	localparam logic [exp_w-1:0] exp_max = {1'b0, {(exp_w-1){1'b1}}};
	localparam logic [exp_w-1:0] exp_min = {1'b1, {(exp_w-1){1'b0}}};

	// mantissas carry one guard bit above the sign
	logic [exp_w-1:0] acc_exp;
	logic [mant_w:0] acc_mant;
	logic [exp_w-1:0] opb_exp;
	logic [mant_w:0] opb_mant;
	logic swapped;
	logic [mant_w:0] sum;

	// after a swap the operands sit the other way round
	always_comb begin
		if (!ctl.sub)
			sum = acc_mant + opb_mant;
		else if (swapped)
			sum = opb_mant - acc_mant;
		else
			sum = acc_mant - opb_mant;
	end

	always_ff @(posedge got_fp) begin
		if (ctl.load_a) begin
			acc_exp <= a.exp;
			acc_mant <= {a.mant[mant_w-1], a.mant};
		end
		if (ctl.load_b) begin
			opb_exp <= b.exp;
			opb_mant <= {b.mant[mant_w-1], b.mant};
		end
		if (ctl.swap) begin
			acc_exp <= opb_exp;
			acc_mant <= opb_mant;
			opb_exp <= acc_exp;
			opb_mant <= acc_mant;
		end
		// one bit per step, truncating
		if (ctl.align_shift) begin
			opb_mant <= $signed(opb_mant) >>> 1;
			opb_exp <= opb_exp + 1'b1;
		end
		if (ctl.add | ctl.sub)
			acc_mant <= sum;
		if (ctl.fix_ovf) begin
			acc_mant <= $signed(acc_mant) >>> 1;
			acc_exp <= acc_exp + 1'b1;
		end
		if (ctl.norm_shift) begin
			acc_mant <= {acc_mant[mant_w-1:0], 1'b0};
			acc_exp <= acc_exp - 1'b1;
		end
		if (ctl.zero_exp)
			acc_exp <= '0;
	end

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			swapped <= 1'b0;
			result <= '0;
		end else begin
			if (ctl.load_a)
				swapped <= 1'b0;
			else if (ctl.swap)
				swapped <= 1'b1;
			if (ctl.store)
				result <= '{exp: acc_exp, mant: acc_mant[mant_w-1:0]};
		end
	end

	assign flags.exp_a_less = $signed(acc_exp) < $signed(opb_exp);
	assign flags.exp_diff_done = (acc_exp == opb_exp);
	assign flags.mant_ovf = acc_mant[mant_w] ^ acc_mant[mant_w-1];
	assign flags.normal = acc_mant[mant_w-1] ^ acc_mant[mant_w-2];
	assign flags.mant_zero = (acc_mant == '0);
	// the inc or dec now being enabled would wrap
	assign flags.exp_range_err = (ctl.fix_ovf & (acc_exp == exp_max)) |
		(ctl.norm_shift & (acc_exp == exp_min));

endmodule

`default_nettype wire

// ==== design/fp_apb_regs.sv ====
`default_nettype none

`include "fp_params.svh"

module fp_apb_regs (
	input logic got_fp,
	input logic _0_f,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output fp_pkg::fp_num_t a,
	output fp_pkg::fp_num_t b,
	output logic start,
	output fp_pkg::fp_op_e op,
	input fp_pkg::fp_num_t result,
	input fp_pkg::fp_status_t status
);

	import fp_pkg::*;

	localparam int exp_w = `FP_EXP_W;

	logic addr_ok;
	logic read_only;
	logic cmd_sel;
	logic access;
	logic wr_ok;

	// register map, exponents sign-extended
	always_comb begin
		addr_ok = 1'b1;
		read_only = 1'b0;
		cmd_sel = 1'b0;
		case (paddr)
			`FP_ADDR_A_MANT: prdata = a.mant;
			`FP_ADDR_A_EXP: prdata = {{(32-exp_w){a.exp[exp_w-1]}}, a.exp};
			`FP_ADDR_B_MANT: prdata = b.mant;
			`FP_ADDR_B_EXP: prdata = {{(32-exp_w){b.exp[exp_w-1]}}, b.exp};
			`FP_ADDR_CMD: begin
				cmd_sel = 1'b1;
				prdata = {30'b0, op};
			end
			`FP_ADDR_STATUS: begin
				read_only = 1'b1;
				prdata = {{(32-$bits(fp_status_t)){1'b0}}, status};
			end
			`FP_ADDR_R_MANT: begin
				read_only = 1'b1;
				prdata = result.mant;
			end
			`FP_ADDR_R_EXP: begin
				read_only = 1'b1;
				prdata = {{(32-exp_w){result.exp[exp_w-1]}}, result.exp};
			end
			default: begin
				addr_ok = 1'b0;
				prdata = '0;
			end
		endcase
	end

	// no wait states
	assign pready = 1'b1;
	assign access = psel & penable;
	assign pslverr = access &
		(~addr_ok | (pwrite & (read_only | (cmd_sel & status.busy))));
	assign wr_ok = access & pwrite & ~pslverr;

	always_ff @(posedge got_fp) begin
		if (wr_ok) begin
			case (paddr)
				`FP_ADDR_A_MANT: a.mant <= pwdata;
				`FP_ADDR_A_EXP: a.exp <= pwdata[exp_w-1:0];
				`FP_ADDR_B_MANT: b.mant <= pwdata;
				`FP_ADDR_B_EXP: b.exp <= pwdata[exp_w-1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			start <= 1'b0;
			op <= op_nrf;
		end else begin
			start <= wr_ok & cmd_sel;
			if (wr_ok & cmd_sel)
				op <= fp_op_e'(pwdata[1:0]);
		end
	end

endmodule

`default_nettype wire

// ==== design/fp_unit.sv ====
`default_nettype none

`include "fp_params.svh"

module fp_unit (
	input logic got_fp,
	input logic _0_f,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic fp_irq
);

	import fp_pkg::*;

	fp_num_t a;
	fp_num_t b;
	fp_num_t result;
	fp_op_e op;
	fp_status_t status;
	fp_ctl_t ctl;
	fp_flags_t flags;
	logic start;
	logic step_trig;
	logic step_busy;
	logic irq_trig;

	fp_apb_regs regs0 (
		.got_fp(got_fp),
		._0_f(_0_f),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.a(a),
		.b(b),
		.start(start),
		.op(op),
		.result(result),
		.status(status)
	);

	fp_sequencer seq0 (
		.got_fp(got_fp),
		._0_f(_0_f),
		.start(start),
		.op(op),
		.flags(flags),
		.step_busy(step_busy),
		.step_trig(step_trig),
		.ctl(ctl),
		.irq_trig(irq_trig),
		.status(status)
	);

	fp_datapath dp0 (
		.got_fp(got_fp),
		._0_f(_0_f),
		.a(a),
		.b(b),
		.ctl(ctl),
		.flags(flags),
		.result(result)
	);

	// paces each microstep
	fp_univib #(.ticks(`FP_STEP_TICKS)) step_vib (
		.got_fp(got_fp),
		._0_f(_0_f),
		.trig(step_trig),
		.q(step_busy)
	);

	// end-of-operation pulse
	fp_univib #(.ticks(`FP_IRQ_TICKS)) irq_vib (
		.got_fp(got_fp),
		._0_f(_0_f),
		.trig(irq_trig),
		.q(fp_irq)
	);

endmodule

`default_nettype wire

// ==== verif/fp_unit_tb.sv ====
`default_nettype none

`include "fp_params.svh"

module fp_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [1:0] op_nrf = 2'd0;
	localparam logic [1:0] op_ad = 2'd1;
	localparam logic [1:0] op_sd = 2'd2;
	localparam int num_tests = 49;
	localparam int cycle_limit = num_tests * 80 * (`FP_STEP_TICKS + 1);
	localparam longint mant_top = 64'sh80000000;
	localparam longint mant_half = 64'sh40000000;

	logic got_fp;
	logic _0_f;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic fp_irq;

	string cur_name;
	int test_errs;
	int n_pass;
	int n_fail;
	int cycles;

	fp_unit dut0 (
		.got_fp(got_fp),
		._0_f(_0_f),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fp_irq(fp_irq)
	);

	always #10 got_fp = ~got_fp;

	// watchdog over the whole run
	always @(posedge got_fp) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("ERROR %s %s: expected %h, actual %h", cur_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_name = name;
		test_errs = 0;
	endtask

	task automatic end_test;
		if (test_errs == 0) begin
			n_pass++;
			$display("%s: passed", cur_name);
		end else begin
			n_fail++;
			$display("%s: failed with %0d errors", cur_name, test_errs);
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(negedge got_fp);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge got_fp);
		penable = 1'b1;
		// halfway to the rising edge, access phase outputs are settled
		#5;
		err = pslverr;
		check("pready", 32'd1, {31'd0, pready});
		@(negedge got_fp);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge got_fp);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge got_fp);
		penable = 1'b1;
		#5;
		data = prdata;
		err = pslverr;
		check("pready", 32'd1, {31'd0, pready});
		@(negedge got_fp);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check("pslverr on write", 32'd0, {31'd0, err});
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		apb_read(addr, data, err);
		check("pslverr on read", 32'd0, {31'd0, err});
	endtask

	task automatic start_op(input logic [1:0] opc);
		write_reg(`FP_ADDR_CMD, {30'd0, opc});
		@(negedge got_fp);
		check("busy after command", 32'd1, {31'd0, dut0.status.busy});
	endtask

	// busy must hold until fp_irq rises, then the pulse is timed
	task automatic wait_done;
		int width;
		while (fp_irq !== 1'b1 && dut0.status.busy === 1'b1)
			@(negedge got_fp);
		check("fp_irq at end of busy", 32'd1, {31'd0, fp_irq});
		check("busy at fp_irq", 32'd0, {31'd0, dut0.status.busy});
		width = 0;
		while (fp_irq === 1'b1) begin
			width++;
			@(negedge got_fp);
		end
		check("fp_irq width", `FP_IRQ_TICKS, width);
	endtask

	// value is mant * 2^exp; align, add, fix overflow, normalize
	function automatic void model(input logic [1:0] opc, input int a_exp,
		input logic [31:0] a_mant, input int b_exp, input logic [31:0] b_mant,
		output int r_exp, output logic [31:0] r_mant, output logic [3:0] r_status);
		longint m;
		longint mb;
		int e;
		int d;
		logic ovf;
		logic unf;
		ovf = 1'b0;
		unf = 1'b0;
		m = longint'($signed(a_mant));
		e = a_exp;
		if (opc != op_nrf) begin
			mb = longint'($signed(b_mant));
			if (a_exp < b_exp) begin
				d = b_exp - a_exp;
				m = m >>> ((d < 31) ? d : 31);
				e = b_exp;
			end else begin
				d = a_exp - b_exp;
				mb = mb >>> ((d < 31) ? d : 31);
			end
			m = (opc == op_sd) ? m - mb : m + mb;
			if (m >= mant_top || m < -mant_top) begin
				m = m >>> 1;
				e++;
				if (e > 127) begin
					ovf = 1'b1;
					e -= 256;
				end
			end
		end
		if (m == 0) begin
			e = 0;
		end else begin
			while (m < mant_half && m >= -mant_half) begin
				m = m * 2;
				e--;
				if (e < -128) begin
					unf = 1'b1;
					e += 256;
				end
			end
		end
		r_exp = e;
		r_mant = m[31:0];
		r_status = {1'b0, ovf, unf, m == 0};
	endfunction

	task automatic load_operands(input int a_exp, input logic [31:0] a_mant, input int b_exp,
		input logic [31:0] b_mant);
		write_reg(`FP_ADDR_A_MANT, a_mant);
		write_reg(`FP_ADDR_A_EXP, a_exp);
		write_reg(`FP_ADDR_B_MANT, b_mant);
		write_reg(`FP_ADDR_B_EXP, b_exp);
	endtask

	task automatic check_result(input int e_exp, input logic [31:0] e_mant,
		input logic [3:0] e_status);
		logic [31:0] rd;
		read_reg(`FP_ADDR_R_MANT, rd);
		check("result mantissa", e_mant, rd);
		read_reg(`FP_ADDR_R_EXP, rd);
		check("result exponent", e_exp, rd);
		read_reg(`FP_ADDR_STATUS, rd);
		check("status", {28'd0, e_status}, rd);
	endtask

	task automatic run_case(input string name, input logic [1:0] opc, input int a_exp,
		input logic [31:0] a_mant, input int b_exp, input logic [31:0] b_mant);
		int e_exp;
		logic [31:0] e_mant;
		logic [3:0] e_status;
		begin_test(name);
		load_operands(a_exp, a_mant, b_exp, b_mant);
		model(opc, a_exp, a_mant, b_exp, b_mant, e_exp, e_mant, e_status);
		start_op(opc);
		wait_done();
		check_result(e_exp, e_mant, e_status);
		end_test();
	endtask

	initial begin
		int seed;
		int ae;
		int be;
		int e_exp;
		logic [31:0] am;
		logic [31:0] bm;
		logic [31:0] rd;
		logic [31:0] old_mant;
		logic [31:0] e_mant;
		logic [3:0] e_status;
		logic [1:0] opc;
		logic err;
		got_fp = 1'b0;
		_0_f = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		n_pass = 0;
		n_fail = 0;
		cycles = 0;
		seed = $urandom(45);
		repeat (16) @(negedge got_fp);
		_0_f = 1'b0;

		begin_test("reset");
		check("fp_irq", 32'd0, {31'd0, fp_irq});
		check_result(0, 32'h0, 4'h0);
		end_test();

		run_case("nrf_small", op_nrf, 5, 32'h0000_0123, 0, 32'h0);
		run_case("nrf_negative", op_nrf, -3, 32'hFFFF_F000, 0, 32'h0);
		run_case("nrf_zero", op_nrf, 17, 32'h0, 0, 32'h0);
		run_case("nrf_normal", op_nrf, 10, 32'h5A5A_5A5A, 0, 32'h0);

		// every 4th pair has equal exponents, the next a gap of 31 or more
		for (int i = 0; i < 40; i++) begin
			opc = (i % 2 == 1) ? op_sd : op_ad;
			am = $urandom;
			bm = $urandom;
			ae = int'($urandom_range(80)) - 40;
			case (i % 4)
				0: be = ae;
				1: be = (i % 8 == 1) ? ae + 31 + int'($urandom_range(20)) :
					ae - 31 - int'($urandom_range(20));
				default: be = int'($urandom_range(40)) - 20;
			endcase
			// large same-sign sums to force mantissa overflow
			if (i % 5 == 0) begin
				be = ae;
				am = {2'b01, am[29:0]};
				bm = (opc == op_ad) ? {2'b01, bm[29:0]} : {2'b10, bm[29:0]};
			end
			run_case($sformatf("%s_%02d", (opc == op_sd) ? "sd" : "ad", i), opc, ae, am, be, bm);
		end

		run_case("exp_ovf", op_ad, 127, 32'h4000_0000, 127, 32'h4000_0000);
		run_case("exp_unf", op_nrf, -128, 32'h0000_0001, 0, 32'h0);

		begin_test("cmd_while_busy");
		load_operands(40, 32'h4000_0000, 38, 32'h1234_5678);
		// result still holds the exp_unf value
		model(op_nrf, -128, 32'h0000_0001, 0, 32'h0, e_exp, old_mant, e_status);
		model(op_ad, 40, 32'h4000_0000, 38, 32'h1234_5678, e_exp, e_mant, e_status);
		start_op(op_ad);
		apb_write(`FP_ADDR_CMD, {30'd0, op_sd}, err);
		check("pslverr on busy command", 32'd1, {31'd0, err});
		read_reg(`FP_ADDR_R_MANT, rd);
		check("result while busy", old_mant, rd);
		wait_done();
		check_result(e_exp, e_mant, e_status);
		end_test();

		begin_test("bus_errors");
		old_mant = e_mant;
		apb_write(8'h20, 32'h1, err);
		check("pslverr unknown write", 32'd1, {31'd0, err});
		apb_read(8'h24, rd, err);
		check("pslverr unknown read", 32'd1, {31'd0, err});
		apb_write(`FP_ADDR_STATUS, 32'hF, err);
		check("pslverr status write", 32'd1, {31'd0, err});
		apb_write(`FP_ADDR_R_MANT, 32'hDEAD_BEEF, err);
		check("pslverr result mantissa write", 32'd1, {31'd0, err});
		apb_write(`FP_ADDR_R_EXP, 32'h55, err);
		check("pslverr result exponent write", 32'd1, {31'd0, err});
		read_reg(`FP_ADDR_R_MANT, rd);
		check("result after bad writes", old_mant, rd);
		end_test();

		$display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/fp_pkg.sv
design/fp_univib.sv
design/fp_sequencer.sv
design/fp_datapath.sv
design/fp_apb_regs.sv
design/fp_unit.sv
verif/fp_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module fp_unit_tb -o fp_unit_sim
./obj_dir/fp_unit_sim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
